// ==== filelist.f ====
hdl/game_pkg.sv
hdl/display_pkg.sv
hdl/button_decoder.sv
hdl/mode_selector.sv
hdl/score_percent.sv
hdl/segment_scanner.sv
hdl/score_console.sv
test/score_console_tb.sv

// ==== hdl/button_decoder.sv ====
/* debounce for the up, down and center push-buttons,
   one-cycle strobe on each clean press */
`timescale 1ns/10ps

module button_decoder #(
  parameter int debounce_cycles = 1_000_000
) (
  input  logic clk_in,
  input  logic reset,
  input  logic btn_up,
  input  logic btn_down,
  input  logic btn_center,
  output logic up_press,
  output logic down_press,
  output logic center_press
);

  localparam int cnt_bits = $clog2(debounce_cycles + 1);

  // bit 0 up, bit 1 down, bit 2 center
  logic [2:0] raw;
  logic [2:0] candidate;
  logic [2:0] clean;
  logic [2:0] clean_prev;
  logic [2:0] press;
  logic [cnt_bits-1:0] stable_count [3];

  assign raw = {btn_center, btn_down, btn_up};

  always_ff @(posedge clk_in) begin
    if (reset) begin
      // start settled on whatever is held, so no press comes out of reset
      candidate  <= raw;
      clean      <= raw;
      clean_prev <= raw;
      press      <= '0;
      for (int i = 0; i < 3; i++) begin
        stable_count[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (raw[i] != candidate[i]) begin
          // raw moved, restart the stability window
          candidate[i]    <= raw[i];
          stable_count[i] <= '0;
        end else if (stable_count[i] == cnt_bits'(debounce_cycles)) begin
          clean[i] <= candidate[i];
        end else begin
          stable_count[i] <= stable_count[i] + 1'b1;
        end
      end
      clean_prev <= clean;
      // rising edge of the clean level
      press <= clean & ~clean_prev;
    end
  end

  assign up_press     = press[0];
  assign down_press   = press[1];
  assign center_press = press[2];

  // a press strobe never lasts two cycles
  a_strobe_single: assert property (
    @(posedge clk_in) disable iff (reset)
    (press & $past(press)) == 3'b000
  ) else $error("press strobe held for two cycles: %b", press);

endmodule

// ==== hdl/display_pkg.sv ====
/* seven-segment display types, digit count and the hex glyph table */
package display_pkg;

  // bit order g f e d c b a, active low
  typedef logic [6:0] segments_t;

  // one enable per digit, leftmost digit on bit 7, active low
  typedef logic [7:0] anodes_t;

  // eight hex nibbles, leftmost digit in the top nibble
  typedef logic [31:0] display_word_t;

  localparam int NUM_DIGITS = 8;

  // glyphs for 0 to F
  localparam segments_t HEX_GLYPHS [0:15] = '{
    7'b100_0000,
    7'b111_1001,
    7'b010_0100,
    7'b011_0000,
    7'b001_1001,
    7'b001_0010,
    7'b000_0010,
    7'b111_1000,
    7'b000_0000,
    7'b001_1000,
    7'b000_1000,
    7'b000_0011,
    7'b100_0110,
    7'b010_0001,
    7'b000_0110,
    7'b000_1110
  };

endpackage

// ==== hdl/game_pkg.sv ====
/* game modes, console menu states, score and decimal digit types,
   accuracy scale for the percentage conversion */
package game_pkg;

  // order matters, the menu walks up and down this list
  typedef enum logic [1:0] {
    MODE_KEYBOARD = 2'd0,
    MODE_FOUR     = 2'd1,
    MODE_LEARN    = 2'd2,
    MODE_PLAY     = 2'd3
  } game_mode_t;

  // console level state
  typedef enum logic {
    STATE_MENU    = 1'b0,
    STATE_PLAYING = 1'b1
  } menu_state_t;

  // game score and maximum score
  typedef logic [11:0] score_t;

  // one decimal digit
  typedef logic [3:0] bcd_digit_t;

  // hundreds in the top nibble, ones in the bottom
  typedef logic [11:0] percent_bcd_t;

  // percentage scale
  localparam int ACCURACY_SCALE = 100;

  // decimal places in the percentage
  localparam int PERCENT_DIGITS = 3;

endpackage

// ==== hdl/mode_selector.sv ====
/* saturating game mode menu and the menu/playing state machine */
`timescale 1ns/10ps

module mode_selector (
  input  logic                 clk_in,
  input  logic                 reset,
  input  logic                 up_press,
  input  logic                 down_press,
  input  logic                 center_press,
  input  logic                 game_finish,
  output game_pkg::game_mode_t mode_choice,
  output game_pkg::game_mode_t current_mode,
  output logic                 mode_active
);

  import game_pkg::*;

  menu_state_t state;

  // menu choice, stops at both ends of the list
  always_ff @(posedge clk_in) begin
    if (reset) begin
      mode_choice <= MODE_KEYBOARD;
    end else if (up_press) begin
      if (mode_choice != MODE_PLAY) begin
        mode_choice <= game_mode_t'(mode_choice + 2'd1);
      end
    end else if (down_press) begin
      if (mode_choice != MODE_KEYBOARD) begin
        mode_choice <= game_mode_t'(mode_choice - 2'd1);
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (reset) begin
      state        <= STATE_MENU;
      current_mode <= MODE_PLAY;
    end else begin
      case (state)
        STATE_MENU: begin
          // track the choice until it is committed
          current_mode <= mode_choice;
          if (center_press) begin
            state <= STATE_PLAYING;
          end
        end
        STATE_PLAYING: begin
          if (game_finish) begin
            state <= STATE_MENU;
          end
        end
        default: begin
          state <= STATE_MENU;
        end
      endcase
    end
  end

  assign mode_active = (state == STATE_PLAYING);

  // committed mode is frozen for the whole game
  a_mode_frozen: assert property (
    @(posedge clk_in) disable iff (reset)
    mode_active |=> $stable(current_mode)
  ) else $error("current_mode changed while a game is active");

endmodule

// ==== hdl/score_console.sv ====
/* console top level: button decode, mode menu, score percentage
   and the seven-segment display */
`timescale 1ns/10ps

module score_console #(
  parameter int debounce_cycles = 1_000_000,
  parameter int scan_bits       = 13
) (
  input  logic                   clk_in,
  input  logic                   reset,
  input  logic                   btn_up,
  input  logic                   btn_down,
  input  logic                   btn_center,
  input  logic                   game_finish,
  input  game_pkg::score_t       score,
  input  game_pkg::score_t       max_score,
  output game_pkg::game_mode_t   mode_choice,
  output game_pkg::game_mode_t   current_mode,
  output logic                   mode_active,
  output display_pkg::segments_t seg,
  output display_pkg::anodes_t   anode
);

  import game_pkg::*;
  import display_pkg::*;

  logic          up_press;
  logic          down_press;
  logic          center_press;
  percent_bcd_t  percent_digits;
  display_word_t display_word;

  button_decoder #(
    .debounce_cycles(debounce_cycles)
  ) u_button_decoder (
    .clk_in      (clk_in),
    .reset       (reset),
    .btn_up      (btn_up),
    .btn_down    (btn_down),
    .btn_center  (btn_center),
    .up_press    (up_press),
    .down_press  (down_press),
    .center_press(center_press)
  );

  mode_selector u_mode_selector (
    .clk_in      (clk_in),
    .reset       (reset),
    .up_press    (up_press),
    .down_press  (down_press),
    .center_press(center_press),
    .game_finish (game_finish),
    .mode_choice (mode_choice),
    .current_mode(current_mode),
    .mode_active (mode_active)
  );

  score_percent u_score_percent (
    .clk_in        (clk_in),
    .reset         (reset),
    .game_finish   (game_finish),
    .score         (score),
    .max_score     (max_score),
    .percent_digits(percent_digits)
  );

  // percentage on the three rightmost digits, zeros to the left
  assign display_word = display_word_t'(percent_digits);

  segment_scanner #(
    .scan_bits(scan_bits)
  ) u_segment_scanner (
    .clk_in      (clk_in),
    .reset       (reset),
    .display_word(display_word),
    .seg         (seg),
    .anode       (anode)
  );

endmodule

// ==== hdl/score_percent.sv ====
/* score to whole percentage conversion by repeated subtraction,
   one decimal place at a time, hundreds first */
`timescale 1ns/10ps

module score_percent (
  input  logic                   clk_in,
  input  logic                   reset,
  input  logic                   game_finish,
  input  game_pkg::score_t       score,
  input  game_pkg::score_t       max_score,
  output game_pkg::percent_bcd_t percent_digits
);

  import game_pkg::*;

  // 100 * 4095 fits in 19 bits
  logic [18:0] dividend;
  score_t      divisor;
  logic [1:0]  place;
  logic        busy;
  logic [18:0] place_step;
  bcd_digit_t  cur_digit;

  // ten to the power of the place index
  function automatic logic [6:0] place_weight(input logic [1:0] idx);
    logic [6:0] weight;
    weight = 7'd1;
    for (int k = 0; k < 3; k++) begin
      if (k < int'(idx)) begin
        weight = weight * 7'd10;
      end
    end
    return weight;
  endfunction

  assign place_step = 19'(place_weight(place)) * 19'(divisor);
  assign cur_digit  = percent_digits[4*int'(place) +: 4];

  always_ff @(posedge clk_in) begin
    if (reset) begin
      busy           <= 1'b0;
      place          <= '0;
      percent_digits <= '0;
    end else if (game_finish) begin
      // a new strobe always restarts
      busy           <= 1'b1;
      place          <= 2'(PERCENT_DIGITS - 1);
      percent_digits <= '0;
    end else if (busy) begin
      if (divisor != '0 && dividend >= place_step) begin
        percent_digits[4*int'(place) +: 4] <= cur_digit + 4'd1;
      end else if (place != 2'd0) begin
        place <= place - 2'd1;
      end else begin
        busy <= 1'b0;
      end
    end
  end

  // dividend and divisor
  always_ff @(posedge clk_in) begin
    if (game_finish) begin
      dividend <= 19'(ACCURACY_SCALE * score);
      divisor  <= max_score;
    end else if (busy && divisor != '0 && dividend >= place_step) begin
      dividend <= dividend - place_step;
    end
  end

  // every place must stay a valid decimal digit
  a_digits_decimal: assert property (
    @(posedge clk_in) disable iff (reset)
    percent_digits[11:8] <= 4'd9 && percent_digits[7:4] <= 4'd9 &&
    percent_digits[3:0] <= 4'd9
  ) else $error("percent digit above nine: %h", percent_digits);

endmodule

// ==== hdl/segment_scanner.sv ====
/* eight-digit multiplexed seven-segment driver, leftmost digit first */
`timescale 1ns/10ps

module segment_scanner #(
  parameter int scan_bits = 13
) (
  input  logic                        clk_in,
  input  logic                        reset,
  input  display_pkg::display_word_t  display_word,
  output display_pkg::segments_t      seg,
  output display_pkg::anodes_t        anode
);

  import display_pkg::*;

  // top three bits walk the digits
  logic [scan_bits:0] scan_count;
  logic [2:0]         digit_sel;
  logic [3:0]         nibble;
  int                 digit_pos;

  assign digit_sel = scan_count[scan_bits -: 3];

  // digit 0 is the leftmost, which sits in the top nibble
  assign digit_pos = NUM_DIGITS - 1 - int'(digit_sel);
  assign nibble    = display_word[4*digit_pos +: 4];

  always_ff @(posedge clk_in) begin
    if (reset) begin
      scan_count <= '0;
      // blank until the first scan update
      anode      <= '1;
      seg        <= '1;
    end else begin
      scan_count <= scan_count + 1'b1;
      seg        <= HEX_GLYPHS[nibble];
      anode      <= ~(anodes_t'(1) << digit_pos);
    end
  end

  // never two digits driven together
  a_one_anode: assert property (
    @(posedge clk_in) disable iff (reset)
    $onehot0(~anode)
  ) else $error("more than one anode low: %b", anode);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile the score console testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
sim_bin=score_console_sim

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module score_console_tb \
  -Mdir "$build_dir" -o "$sim_bin"
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$log_file"; then
  exit 0
fi
echo "pass line not found in $log_file"
exit 1

// ==== test/score_console_tb.sv ====
/* score console testbench: stimulus table of button presses and game ends,
   mode output checks and seven-segment scan checks */
`timescale 1ns/10ps

module score_console_tb;

  import game_pkg::*;

  localparam int num_rows    = 19;
  localparam int cycle_limit = num_rows * 60 + 100;

  typedef enum int {OP_UP, OP_DOWN, OP_CENTER, OP_BOUNCE_UP, OP_FINISH} op_t;

  typedef struct {
    op_t          op;
    score_t       score;
    score_t       max_score;
    game_mode_t   exp_choice;
    game_mode_t   exp_current;
    logic         exp_active;
    percent_bcd_t exp_digits;
  } row_t;

  logic                   clk_in;
  logic                   reset;
  logic                   btn_up;
  logic                   btn_down;
  logic                   btn_center;
  logic                   game_finish;
  score_t                 score;
  score_t                 max_score;
  game_mode_t             mode_choice;
  game_mode_t             current_mode;
  logic                   mode_active;
  display_pkg::segments_t seg;
  display_pkg::anodes_t   anode;

  row_t   rows [num_rows];
  integer seed;
  int     row_count;
  int     errors;
  int     checks;
  int     cycle_count;

  score_console #(
    .debounce_cycles(4),
    .scan_bits      (4)
  ) u_score_console (
    .clk_in      (clk_in),
    .reset       (reset),
    .btn_up      (btn_up),
    .btn_down    (btn_down),
    .btn_center  (btn_center),
    .game_finish (game_finish),
    .score       (score),
    .max_score   (max_score),
    .mode_choice (mode_choice),
    .current_mode(current_mode),
    .mode_active (mode_active),
    .seg         (seg),
    .anode       (anode)
  );

  initial begin
    clk_in = 1'b0;
    forever #20 clk_in = ~clk_in;
  end

  // floor of 100 * num / den as three decimal digits, zero for den zero
  function automatic percent_bcd_t expected_percent(input int num, input int den);
    int pct;
    if (den == 0) begin
      pct = 0;
    end else begin
      pct = (100 * num) / den;
    end
    return {4'(pct / 100), 4'((pct / 10) % 10), 4'(pct % 10)};
  endfunction

  // active low, segment a on bit 0 up to g on bit 6
  function automatic display_pkg::segments_t digit_glyph(input logic [3:0] digit);
    string                  lit;
    display_pkg::segments_t glyph;
    // segments lit for each decimal digit
    case (digit)
      4'd0: lit = "abcdef";
      4'd1: lit = "bc";
      4'd2: lit = "abdeg";
      4'd3: lit = "abcdg";
      4'd4: lit = "bcfg";
      4'd5: lit = "acdfg";
      4'd6: lit = "acdefg";
      4'd7: lit = "abc";
      4'd8: lit = "abcdefg";
      4'd9: lit = "abcfg";
      default: lit = "";
    endcase
    glyph = '1;
    for (int i = 0; i < lit.len(); i++) begin
      glyph[lit[i] - "a"] = 1'b0;
    end
    return glyph;
  endfunction

  task automatic add_row(input op_t op, input int sc, input int mx, input game_mode_t choice,
                         input game_mode_t current, input logic active);
    rows[row_count].op          = op;
    rows[row_count].score       = score_t'(sc);
    rows[row_count].max_score   = score_t'(mx);
    rows[row_count].exp_choice  = choice;
    rows[row_count].exp_current = current;
    rows[row_count].exp_active  = active;
    rows[row_count].exp_digits  = expected_percent(sc, mx);
    row_count = row_count + 1;
  endtask

  task automatic build_table();
    int r_max;
    int r_score;
    // walk up past play, then down past keyboard
    add_row(OP_UP, 0, 0, MODE_FOUR, MODE_FOUR, 1'b0);
    add_row(OP_UP, 0, 0, MODE_LEARN, MODE_LEARN, 1'b0);
    add_row(OP_UP, 0, 0, MODE_PLAY, MODE_PLAY, 1'b0);
    add_row(OP_UP, 0, 0, MODE_PLAY, MODE_PLAY, 1'b0);
    add_row(OP_DOWN, 0, 0, MODE_LEARN, MODE_LEARN, 1'b0);
    add_row(OP_DOWN, 0, 0, MODE_FOUR, MODE_FOUR, 1'b0);
    add_row(OP_DOWN, 0, 0, MODE_KEYBOARD, MODE_KEYBOARD, 1'b0);
    add_row(OP_DOWN, 0, 0, MODE_KEYBOARD, MODE_KEYBOARD, 1'b0);
    add_row(OP_BOUNCE_UP, 0, 0, MODE_FOUR, MODE_FOUR, 1'b0);
    // committed mode stays at four during the game
    add_row(OP_CENTER, 0, 0, MODE_FOUR, MODE_FOUR, 1'b1);
    add_row(OP_UP, 0, 0, MODE_LEARN, MODE_FOUR, 1'b1);
    add_row(OP_UP, 0, 0, MODE_PLAY, MODE_FOUR, 1'b1);
    add_row(OP_DOWN, 0, 0, MODE_LEARN, MODE_FOUR, 1'b1);
    add_row(OP_FINISH, 200, 200, MODE_LEARN, MODE_LEARN, 1'b0);
    add_row(OP_FINISH, 37, 0, MODE_LEARN, MODE_LEARN, 1'b0);
    for (int i = 0; i < 4; i++) begin
      r_max   = $random(seed) & 32'h0000_0fff;
      r_score = ($random(seed) & 32'h7fff_ffff) % (r_max + 1);
      add_row(OP_FINISH, r_score, r_max, MODE_LEARN, MODE_LEARN, 1'b0);
    end
  endtask

  task automatic set_button(input int sel, input logic level);
    case (sel)
      0: btn_up = level;
      1: btn_down = level;
      default: btn_center = level;
    endcase
  endtask

  // 0 up, 1 down, 2 center; held 8 cycles, released 8 cycles
  task automatic press_button(input int sel, input bit bounce);
    if (bounce) begin
      for (int i = 0; i < 3; i++) begin
        @(negedge clk_in);
        set_button(sel, (i % 2) == 0);
      end
    end
    @(negedge clk_in);
    set_button(sel, 1'b1);
    repeat (8) @(negedge clk_in);
    set_button(sel, 1'b0);
    repeat (8) @(negedge clk_in);
  endtask

  task automatic finish_game(input score_t sc, input score_t mx);
    @(negedge clk_in);
    score       = sc;
    max_score   = mx;
    game_finish = 1'b1;
    @(negedge clk_in);
    game_finish = 1'b0;
    repeat (50) @(negedge clk_in);
  endtask

  task automatic check_value(input string where, input string name,
                             input logic [31:0] got, input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("CHECK FAILED %s: %s got %h expected %h", where, name, got, exp);
    end
  endtask

  task automatic check_mode(input string where, input game_mode_t choice,
                            input game_mode_t current, input logic active);
    check_value(where, "mode_choice", 32'(mode_choice), 32'(choice));
    check_value(where, "current_mode", 32'(current_mode), 32'(current));
    check_value(where, "mode_active", 32'(mode_active), 32'(active));
  endtask

  // one full scan, five zeros then hundreds, tens, ones
  task automatic check_display(input string where, input percent_bcd_t digits);
    logic [7:0] seen;
    logic [3:0] nibble;
    seen = '0;
    repeat (32) begin
      @(negedge clk_in);
      check_value(where, "anode low count", 32'($countones(~anode)), 32'd1);
      for (int d = 0; d < 8; d++) begin
        if (anode[d] == 1'b0) begin
          seen[d] = 1'b1;
          nibble  = (d < 3) ? digits[4*d +: 4] : 4'd0;
          check_value(where, $sformatf("seg on digit %0d", 7 - d), 32'(seg),
                      32'(digit_glyph(nibble)));
        end
      end
    end
    for (int d = 0; d < 8; d++) begin
      if (!seen[d]) begin
        errors = errors + 1;
        $display("%s: digit %0d was never enabled during the scan", where, 7 - d);
      end
    end
  endtask

  initial begin
    string where;
    reset       = 1'b1;
    btn_up      = 1'b0;
    btn_down    = 1'b0;
    btn_center  = 1'b0;
    game_finish = 1'b0;
    score       = '0;
    max_score   = '0;
    errors      = 0;
    checks      = 0;
    row_count   = 0;
    seed        = 32'h5cd4_4a5d;
    build_table();
    repeat (2) @(posedge clk_in);
    @(negedge clk_in);
    reset = 1'b0;
    // play committed out of reset, then tracks the choice
    check_mode("after reset", MODE_KEYBOARD, MODE_PLAY, 1'b0);
    @(negedge clk_in);
    check_mode("after reset", MODE_KEYBOARD, MODE_KEYBOARD, 1'b0);
    check_display("after reset", 12'h000);
    for (int i = 0; i < num_rows; i++) begin
      where = $sformatf("row %0d", i);
      case (rows[i].op)
        OP_UP: press_button(0, 1'b0);
        OP_DOWN: press_button(1, 1'b0);
        OP_CENTER: press_button(2, 1'b0);
        OP_BOUNCE_UP: press_button(0, 1'b1);
        default: finish_game(rows[i].score, rows[i].max_score);
      endcase
      check_mode(where, rows[i].exp_choice, rows[i].exp_current, rows[i].exp_active);
      if (rows[i].op == OP_FINISH) begin
        check_display(where, rows[i].exp_digits);
      end
    end
    $display("checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // run limit from the table length
  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk_in);
      cycle_count = cycle_count + 1;
    end
    $display("timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("checks run %0d, errors %0d", checks, errors);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
